//--- rtl/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // Cache geometry
    localparam int NUM_SETS = 256;
    localparam int IDX_W    = $clog2(NUM_SETS);
    localparam int TAG_W    = 20;
    localparam int OFS_W    = 4;
    localparam int BANKS    = 4;
    localparam int WORD_W   = 32;
    localparam int ADDR_W   = TAG_W + IDX_W + OFS_W;

    typedef logic [IDX_W-1:0]    index_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [1:0]          bank_t;
    typedef logic [WORD_W/8-1:0] strb_t;
    typedef logic [WORD_W-1:0]   word_t;

    // One CPU request as held in the request buffer
    typedef struct packed {
        logic             op;       // 1 for store, 0 for load
        index_t           index;
        tag_t             tag;
        logic [OFS_W-1:0] offset;
        strb_t            wstrb;
        word_t            wdata;
    } cpu_req_t;

    typedef struct packed {
        tag_t tag;
        logic valid;
    } tagv_t;

    // A cache line, seen per bank or as one flat vector
    typedef union packed {
        word_t [BANKS-1:0]         words;
        logic [BANKS*WORD_W-1:0]   flat;
    } line_u;

    // Write request into one way, shared by store hits and refills
    typedef struct packed {
        logic              way;
        strb_t [BANKS-1:0] strb;
        line_u             data;
        logic              tag_we;
        tag_t              tag;
        logic              dirty_we;
        logic              dirty;
    } bank_wr_t;

    typedef enum logic [4:0] {
        IDLE    = 5'b00001,
        LOOKUP  = 5'b00010,
        MISS    = 5'b00100,
        REPLACE = 5'b01000,
        REFILL  = 5'b10000
    } main_state_e;

endpackage

`default_nettype wire

//--- rtl/cache_way_store.sv
`default_nettype none

module cache_way_store
    import cache_pkg::*;
#(
    parameter bit WAY      = 1'b0,
    parameter int NUM_SETS = cache_pkg::NUM_SETS
) (
    input  wire logic     clk_g,
    input  wire logic     resetn,
    input  wire index_t   index,
    input  wire bank_wr_t wr,
    output tagv_t         tagv,
    output line_u         line,
    output logic          dirty
);

    logic sel;

    tag_t tag_mem [NUM_SETS];

    // Byte-addressable banks, one row per set
    logic [BANKS-1:0][WORD_W/8-1:0][7:0] data_mem [NUM_SETS];

    logic [NUM_SETS-1:0] valid_vec;
    logic [NUM_SETS-1:0] dirty_vec;

    // Only requests addressed to this way are taken
    assign sel = (wr.way == WAY);

    // Storage arrays with registered read ports
    always_ff @(posedge clk_g) begin
        if (sel && wr.tag_we) begin
            tag_mem[index] <= wr.tag;
        end
        for (int b = 0; b < BANKS; b++) begin
            for (int i = 0; i < WORD_W / 8; i++) begin
                if (sel && wr.strb[b][i]) begin
                    data_mem[index][b][i] <= wr.data.words[b][8*i +: 8];
                end
            end
        end
        // Read returns the contents before this edge's write
        tagv.tag   <= tag_mem[index];
        tagv.valid <= valid_vec[index];
        line.flat  <= data_mem[index];
        dirty      <= dirty_vec[index];
    end

    // Valid and dirty flags
    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            valid_vec <= '0;
            dirty_vec <= '0;
        end else begin
            if (sel && wr.tag_we) begin
                valid_vec[index] <= 1'b1;
            end
            if (sel && wr.dirty_we) begin
                dirty_vec[index] <= wr.dirty;
            end
        end
    end

    // Controller and write path keep the storage untouched during reset
    a_no_write_in_reset: assert property (
        @(posedge clk_g) (!resetn ##1 !resetn) |->
            (wr.strb == '0) && !wr.tag_we && !wr.dirty_we
    ) else $error("way %0d written while in reset", WAY);

endmodule

`default_nettype wire

//--- rtl/cache_ctrl.sv
`default_nettype none

module cache_ctrl
    import cache_pkg::*;
#(
    parameter int NUM_SETS = cache_pkg::NUM_SETS
) (
    input  wire logic               clk_g,
    input  wire logic               resetn,
    // CPU side
    input  wire logic               valid,
    input  wire logic               op,
    input  wire index_t             index,
    input  wire tag_t               tag,
    input  wire logic [OFS_W-1:0]   offset,
    input  wire strb_t              wstrb,
    input  wire word_t              wdata,
    output logic                    addr_ok,
    output logic                    data_ok,
    output word_t                   rdata,
    // Memory side
    output logic                    rd_req,
    output logic [ADDR_W-1:0]       rd_addr,
    input  wire logic               rd_rdy,
    output logic                    wr_req,
    output logic [ADDR_W-1:0]       wr_addr,
    output logic [BANKS*WORD_W-1:0] wr_data,
    input  wire logic               wr_rdy,
    // Write path
    input  wire logic               refill_done,
    input  wire logic               refill_ok,
    input  wire word_t              refill_word,
    output logic                    refill_active,
    output cpu_req_t                req,
    output logic                    victim_way,
    output bank_wr_t                hit_wr,
    // Way storage
    input  wire tagv_t              way0_tagv,
    input  wire tagv_t              way1_tagv,
    input  wire line_u              way0_line,
    input  wire line_u              way1_line,
    input  wire logic               way0_dirty,
    input  wire logic               way1_dirty,
    output index_t                  ram_index
);

    // The index must address every set exactly
    if (NUM_SETS != (1 << IDX_W)) begin : g_bad_sets
        $error("NUM_SETS %0d does not match the index width", NUM_SETS);
    end

    main_state_e state;
    main_state_e next_state;

    logic   way0_hit;
    logic   way1_hit;
    logic   hit;
    logic   store_hit;
    bank_t  sel_bank;
    line_u  hit_line;
    logic   pick_way;
    logic   rr_way;
    logic   victim_dirty;
    tag_t   victim_tag;
    line_u  victim_line;

    assign way0_hit  = way0_tagv.valid && (way0_tagv.tag == req.tag);
    assign way1_hit  = way1_tagv.valid && (way1_tagv.tag == req.tag);
    assign hit       = way0_hit || way1_hit;
    assign store_hit = (state == LOOKUP) && hit && req.op;
    assign sel_bank  = req.offset[3:2];
    assign hit_line  = way1_hit ? way1_line : way0_line;

    // Invalid way first, round-robin otherwise
    assign pick_way = !way0_tagv.valid ? 1'b0 :
                      !way1_tagv.valid ? 1'b1 : rr_way;

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:    if (valid) next_state = LOOKUP;
            LOOKUP:  next_state = hit ? IDLE : MISS;
            MISS:    if (!victim_dirty || wr_rdy) next_state = REPLACE;
            REPLACE: if (rd_rdy) next_state = REFILL;
            REFILL:  if (refill_done) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // Request buffer
    always_ff @(posedge clk_g) begin
        if (state == IDLE && valid) begin
            req <= '{op: op, index: index, tag: tag, offset: offset,
                     wstrb: wstrb, wdata: wdata};
        end
    end

    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            rr_way       <= 1'b0;
            victim_way   <= 1'b0;
            victim_dirty <= 1'b0;
        end else begin
            if (refill_done) begin
                rr_way <= ~rr_way;
            end
            if (state == LOOKUP && !hit) begin
                victim_way   <= pick_way;
                victim_dirty <= pick_way ? way1_dirty : way0_dirty;
            end
        end
    end

    // Victim line held for the write-back
    always_ff @(posedge clk_g) begin
        if (state == LOOKUP && !hit) begin
            victim_tag  <= pick_way ? way1_tagv.tag : way0_tagv.tag;
            victim_line <= pick_way ? way1_line : way0_line;
        end
    end

    // Store hit writes its bank at the end of LOOKUP
    always_comb begin
        hit_wr          = '0;
        hit_wr.way      = way1_hit;
        hit_wr.tag      = req.tag;
        hit_wr.dirty_we = store_hit;
        hit_wr.dirty    = 1'b1;
        for (int b = 0; b < BANKS; b++) begin
            hit_wr.data.words[b] = req.wdata;
            if (store_hit && sel_bank == bank_t'(b)) begin
                hit_wr.strb[b] = req.wstrb;
            end
        end
    end

    assign ram_index     = (state == IDLE) ? index : req.index;
    assign refill_active = (state == REFILL);

    assign addr_ok = (state == IDLE) && valid;
    assign data_ok = ((state == LOOKUP) && hit) || refill_ok;
    assign rdata   = (state == REFILL) ? refill_word : hit_line.words[sel_bank];

    assign rd_req  = (state == REPLACE);
    assign rd_addr = {req.tag, req.index, {OFS_W{1'b0}}};
    assign wr_req  = (state == MISS) && victim_dirty;
    assign wr_addr = {victim_tag, req.index, {OFS_W{1'b0}}};
    assign wr_data = victim_line.flat;

    // A line never lives in both ways
    a_single_hit: assert property (
        @(posedge clk_g) disable iff (!resetn)
        (state == LOOKUP) |-> !(way0_hit && way1_hit)
    ) else $error("tag %h hits in both ways", req.tag);

    a_req_exclusive: assert property (
        @(posedge clk_g) disable iff (!resetn)
        !(rd_req && wr_req)
    ) else $error("read and write requests overlap");

endmodule

`default_nettype wire

//--- rtl/cache_write_path.sv
`default_nettype none

module cache_write_path
    import cache_pkg::*;
(
    input  wire logic     clk_g,
    input  wire logic     resetn,
    input  wire logic     ret_valid,
    input  wire logic     ret_last,
    input  wire word_t    ret_data,
    input  wire logic     refill_active,
    input  wire cpu_req_t req,
    input  wire logic     victim_way,
    input  wire bank_wr_t hit_wr,
    output bank_wr_t      wr,
    output logic          refill_done,
    output logic          refill_ok,
    output word_t         refill_word
);

    bank_t beat;
    logic  req_beat;
    word_t merged;
    word_t beat_word;

    // Beat counter, one step per returned word
    always_ff @(posedge clk_g) begin
        if (!resetn) begin
            beat <= '0;
        end else if (ret_valid) begin
            if (ret_last) begin
                beat <= '0;
            end else begin
                beat <= beat + 2'd1;
            end
        end
    end

    assign req_beat = (beat == req.offset[3:2]);

    // Store bytes replace the returned bytes under the strobe
    always_comb begin
        for (int i = 0; i < WORD_W / 8; i++) begin
            if (req.op && req.wstrb[i]) begin
                merged[8*i +: 8] = req.wdata[8*i +: 8];
            end else begin
                merged[8*i +: 8] = ret_data[8*i +: 8];
            end
        end
    end

    assign beat_word   = req_beat ? merged : ret_data;
    assign refill_word = merged;
    assign refill_ok   = refill_active && ret_valid && req_beat;
    assign refill_done = refill_active && ret_valid && ret_last;

    always_comb begin
        wr = hit_wr;
        if (refill_active) begin
            wr     = '0;
            wr.way = victim_way;
            for (int b = 0; b < BANKS; b++) begin
                wr.data.words[b] = beat_word;
            end
            if (ret_valid) begin
                wr.strb[beat] = '1;
            end
            // Tag and dirty are written once, with the last beat
            wr.tag_we   = refill_done;
            wr.tag      = req.tag;
            wr.dirty_we = refill_done;
            wr.dirty    = req.op;
        end
    end

    a_ret_in_refill: assert property (
        @(posedge clk_g) disable iff (!resetn)
        ret_valid |-> refill_active
    ) else $error("returned data outside a refill");

endmodule

`default_nettype wire

//--- rtl/cache_top.sv
`default_nettype none

module cache_top
    import cache_pkg::*;
#(
    parameter int NUM_SETS = cache_pkg::NUM_SETS
) (
    input  wire logic               clk_g,
    input  wire logic               resetn,
    // CPU side
    input  wire logic               valid,
    input  wire logic               op,
    input  wire index_t             index,
    input  wire tag_t               tag,
    input  wire logic [OFS_W-1:0]   offset,
    input  wire strb_t              wstrb,
    input  wire word_t              wdata,
    output logic                    addr_ok,
    output logic                    data_ok,
    output word_t                   rdata,
    // Memory side
    output logic                    rd_req,
    output logic [ADDR_W-1:0]       rd_addr,
    input  wire logic               rd_rdy,
    input  wire logic               ret_valid,
    input  wire logic               ret_last,
    input  wire word_t              ret_data,
    output logic                    wr_req,
    output logic [ADDR_W-1:0]       wr_addr,
    output logic [BANKS*WORD_W-1:0] wr_data,
    input  wire logic               wr_rdy
);

    index_t   ram_index;
    cpu_req_t req;
    logic     victim_way;
    logic     refill_active;
    logic     refill_done;
    logic     refill_ok;
    word_t    refill_word;
    bank_wr_t hit_wr;
    bank_wr_t way_wr;
    tagv_t    way0_tagv;
    tagv_t    way1_tagv;
    line_u    way0_line;
    line_u    way1_line;
    logic     way0_dirty;
    logic     way1_dirty;

    cache_ctrl #(
        .NUM_SETS (NUM_SETS)
    ) ctrl_i (
        .clk_g, .resetn,
        .valid, .op, .index, .tag, .offset, .wstrb, .wdata,
        .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_addr, .rd_rdy,
        .wr_req, .wr_addr, .wr_data, .wr_rdy,
        .refill_done, .refill_ok, .refill_word,
        .refill_active, .req, .victim_way, .hit_wr,
        .way0_tagv, .way1_tagv, .way0_line, .way1_line,
        .way0_dirty, .way1_dirty,
        .ram_index
    );

    // Both ways see the same write request and pick their own
    cache_way_store #(
        .WAY      (1'b0),
        .NUM_SETS (NUM_SETS)
    ) way0_i (
        .clk_g, .resetn,
        .index (ram_index),
        .wr    (way_wr),
        .tagv  (way0_tagv),
        .line  (way0_line),
        .dirty (way0_dirty)
    );

    cache_way_store #(
        .WAY      (1'b1),
        .NUM_SETS (NUM_SETS)
    ) way1_i (
        .clk_g, .resetn,
        .index (ram_index),
        .wr    (way_wr),
        .tagv  (way1_tagv),
        .line  (way1_line),
        .dirty (way1_dirty)
    );

    cache_write_path write_path_i (
        .clk_g, .resetn,
        .ret_valid, .ret_last, .ret_data,
        .refill_active, .req, .victim_way, .hit_wr,
        .wr (way_wr),
        .refill_done, .refill_ok, .refill_word
    );

endmodule

`default_nettype wire

//--- testbench/cache_checker.sv
`default_nettype none

module cache_checker
    import cache_pkg::*;
(
    input  wire logic                    clk_g,
    input  wire logic                    resetn,
    input  wire logic                    valid,
    input  wire logic                    addr_ok,
    input  wire logic                    data_ok,
    input  wire word_t                   rdata,
    input  wire logic                    rd_req,
    input  wire logic [ADDR_W-1:0]       rd_addr,
    input  wire logic                    wr_req,
    input  wire logic [ADDR_W-1:0]       wr_addr,
    input  wire logic [BANKS*WORD_W-1:0] wr_data,
    input  wire logic                    wr_rdy,
    // Expected values from the testbench model
    input  wire logic                    exp_load,
    input  wire logic                    exp_hit,
    input  wire logic                    exp_wb,
    input  wire word_t                   exp_rdata,
    input  wire logic [ADDR_W-1:0]       exp_rd_addr,
    input  wire logic [ADDR_W-1:0]       exp_wb_addr,
    input  wire logic [BANKS*WORD_W-1:0] exp_wb_data,
    output int                           err_count
);

    logic                    seen_valid;
    logic                    hit_wait;
    logic                    wr_hold;
    logic                    rd_seen;
    logic                    wb_seen;
    logic [ADDR_W-1:0]       last_wr_addr;
    logic [BANKS*WORD_W-1:0] last_wr_data;

    task automatic report_error(input string msg);
        err_count = err_count + 1;
        $display("Error at time %0t: %s", $time, msg);
    endtask

    // Sampled on the rising edge, where all DUT outputs are settled
    always @(posedge clk_g) begin
        if (!resetn) begin
            err_count  = 0;
            seen_valid = 1'b0;
            hit_wait   = 1'b0;
            wr_hold    = 1'b0;
            rd_seen    = 1'b0;
            wb_seen    = 1'b0;
        end else begin
            if (valid) begin
                seen_valid = 1'b1;
            end
            if (!seen_valid && (addr_ok || data_ok || rd_req || wr_req)) begin
                report_error("handshake output high before the first request");
            end
            // Hit answers in the cycle right after acceptance
            if (hit_wait && !data_ok) begin
                report_error("hit without data_ok one cycle after addr_ok");
            end
            hit_wait = addr_ok && exp_hit;
            if (data_ok && exp_load && rdata !== exp_rdata) begin
                report_error($sformatf("rdata %h, expected %h", rdata, exp_rdata));
            end
            // A miss reads its line and first writes back a dirty victim
            if (data_ok && !exp_hit && !rd_seen) begin
                report_error("miss finished without reading its line");
            end
            if (data_ok && exp_wb && !wb_seen) begin
                report_error("dirty victim was not written back");
            end
            if (addr_ok) begin
                rd_seen = 1'b0;
                wb_seen = 1'b0;
            end
            if (rd_req) begin
                rd_seen = 1'b1;
            end
            if (wr_req && wr_rdy) begin
                wb_seen = 1'b1;
            end
            if (rd_req && exp_hit) begin
                report_error("rd_req raised for a hit");
            end
            if (rd_req && rd_addr !== exp_rd_addr) begin
                report_error($sformatf("rd_addr %h, expected %h", rd_addr, exp_rd_addr));
            end
            if (wr_req && !exp_wb) begin
                report_error("wr_req raised for a clean victim");
            end
            if (wr_req && exp_wb && wr_addr !== exp_wb_addr) begin
                report_error($sformatf("wr_addr %h, expected %h", wr_addr, exp_wb_addr));
            end
            if (wr_req && exp_wb && wr_data !== exp_wb_data) begin
                report_error($sformatf("wr_data %h, expected %h", wr_data, exp_wb_data));
            end
            // Write-back must hold steady until wr_rdy
            if (wr_hold && !wr_req) begin
                report_error("wr_req dropped before wr_rdy");
            end
            if (wr_hold && wr_req &&
                (wr_addr !== last_wr_addr || wr_data !== last_wr_data)) begin
                report_error("write-back changed while waiting for wr_rdy");
            end
            wr_hold      = wr_req && !wr_rdy;
            last_wr_addr = wr_addr;
            last_wr_data = wr_data;
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_cache.sv
`default_nettype none

module tb_cache
    import cache_pkg::*;
();

    typedef struct packed {
        logic        op;
        logic [31:0] addr;
        strb_t       strb;
        word_t       data;
    } stim_t;

    localparam int NUM_STIM = 13;
    localparam int TIMEOUT  = 200;
    localparam int SHADOW_N = 64;

    logic                    clk_g;
    logic                    resetn;
    logic                    valid;
    logic                    op;
    index_t                  index;
    tag_t                    tag;
    logic [OFS_W-1:0]        offset;
    strb_t                   wstrb;
    word_t                   wdata;
    logic                    addr_ok;
    logic                    data_ok;
    word_t                   rdata;
    logic                    rd_req;
    logic [ADDR_W-1:0]       rd_addr;
    logic                    rd_rdy;
    logic                    ret_valid;
    logic                    ret_last;
    word_t                   ret_data;
    logic                    wr_req;
    logic [ADDR_W-1:0]       wr_addr;
    logic [BANKS*WORD_W-1:0] wr_data;
    logic                    wr_rdy;

    // Expected results of the request in flight
    logic                    exp_load;
    logic                    exp_hit;
    logic                    exp_wb;
    word_t                   exp_rdata;
    logic [ADDR_W-1:0]       exp_rd_addr;
    logic [ADDR_W-1:0]       exp_wb_addr;
    logic [BANKS*WORD_W-1:0] exp_wb_data;

    int     err_count;
    int     timeouts;
    integer seed;
    stim_t  stim [NUM_STIM];

    // Shadow memory keeps only the words written back so far
    logic [29:0] sh_addr [SHADOW_N];
    word_t       sh_data [SHADOW_N];
    int          sh_cnt;

    // Cache model, entry is way * NUM_SETS + index
    tag_t                    m_tag   [2*NUM_SETS];
    logic                    m_valid [2*NUM_SETS];
    logic                    m_dirty [2*NUM_SETS];
    logic [BANKS*WORD_W-1:0] m_line  [2*NUM_SETS];
    logic                    m_rr;

    // Memory-side responder state
    int          wr_wait;
    int          rd_wait;
    logic        ret_act;
    logic [1:0]  ret_beat;
    logic [31:0] ret_base;

    cache_top #(
        .NUM_SETS (NUM_SETS)
    ) dut_i (
        .clk_g, .resetn,
        .valid, .op, .index, .tag, .offset, .wstrb, .wdata,
        .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_addr, .rd_rdy,
        .ret_valid, .ret_last, .ret_data,
        .wr_req, .wr_addr, .wr_data, .wr_rdy
    );

    cache_checker chk_i (
        .clk_g, .resetn, .valid,
        .addr_ok, .data_ok, .rdata,
        .rd_req, .rd_addr, .wr_req, .wr_addr, .wr_data, .wr_rdy,
        .exp_load, .exp_hit, .exp_wb, .exp_rdata,
        .exp_rd_addr, .exp_wb_addr, .exp_wb_data,
        .err_count
    );

    always #5 clk_g = ~clk_g;

    // Untouched words hold their word address XOR a fixed pattern
    function automatic word_t shadow_read(input logic [31:0] addr);
        word_t val;
        val = {2'b00, addr[31:2]} ^ 32'h5A5A0000;
        for (int i = 0; i < sh_cnt; i++) begin
            if (sh_addr[i] == addr[31:2]) begin
                val = sh_data[i];
            end
        end
        return val;
    endfunction

    task automatic shadow_write(input logic [31:0] addr, input word_t val);
        int slot;
        slot = sh_cnt;
        for (int i = 0; i < sh_cnt; i++) begin
            if (sh_addr[i] == addr[31:2]) begin
                slot = i;
            end
        end
        if (slot == sh_cnt && sh_cnt < SHADOW_N) begin
            sh_cnt++;
        end
        sh_addr[slot] = addr[31:2];
        sh_data[slot] = val;
    endtask

    // Steps the cache model and sets the expected values
    task automatic model_access(input stim_t s);
        index_t idx;
        tag_t   tg;
        bank_t  bk;
        int     w;
        int     e;
        logic   wb;
        word_t  word;
        idx = s.addr[11:4];
        tg  = s.addr[31:12];
        bk  = s.addr[3:2];
        w   = -1;
        for (int k = 0; k < 2; k++) begin
            e = k * NUM_SETS + idx;
            if (m_valid[e] && m_tag[e] == tg) begin
                w = k;
            end
        end
        exp_hit <= (w >= 0);
        exp_wb  <= 1'b0;
        if (w < 0) begin
            // Invalid way first, then the round-robin bit
            if (!m_valid[idx]) begin
                w = 0;
            end else if (!m_valid[NUM_SETS + idx]) begin
                w = 1;
            end else begin
                w = m_rr;
            end
            e  = w * NUM_SETS + idx;
            wb = m_valid[e] && m_dirty[e];
            exp_wb      <= wb;
            exp_wb_addr <= {m_tag[e], idx, 4'h0};
            exp_wb_data <= m_line[e];
            for (int b = 0; b < BANKS; b++) begin
                if (wb) begin
                    shadow_write({m_tag[e], idx, bank_t'(b), 2'b00}, m_line[e][32*b +: 32]);
                end
                m_line[e][32*b +: 32] = shadow_read({tg, idx, bank_t'(b), 2'b00});
            end
            m_tag[e]   = tg;
            m_valid[e] = 1'b1;
            m_dirty[e] = 1'b0;
            m_rr       = ~m_rr;
        end
        e    = w * NUM_SETS + idx;
        word = m_line[e][32*bk +: 32];
        if (s.op) begin
            for (int i = 0; i < 4; i++) begin
                if (s.strb[i]) begin
                    word[8*i +: 8] = s.data[8*i +: 8];
                end
            end
            m_line[e][32*bk +: 32] = word;
            m_dirty[e] = 1'b1;
        end
        exp_rdata   <= word;
        exp_load    <= !s.op;
        exp_rd_addr <= {tg, idx, 4'h0};
    endtask

    // One request, accepted on addr_ok and finished on data_ok
    task automatic apply_entry(input int n);
        int cnt;
        @(posedge clk_g);
        valid  <= 1'b1;
        op     <= stim[n].op;
        tag    <= stim[n].addr[31:12];
        index  <= stim[n].addr[11:4];
        offset <= stim[n].addr[3:0];
        wstrb  <= stim[n].strb;
        wdata  <= stim[n].data;
        model_access(stim[n]);
        cnt = 0;
        do begin
            @(posedge clk_g);
            cnt++;
        end while (!addr_ok && cnt < TIMEOUT);
        valid <= 1'b0;
        if (!addr_ok) begin
            $display("Timeout: request %0d was never accepted", n);
            timeouts++;
            return;
        end
        cnt = 0;
        do begin
            @(posedge clk_g);
            cnt++;
        end while (!data_ok && cnt < TIMEOUT);
        if (!data_ok) begin
            $display("Timeout: request %0d never returned data_ok", n);
            timeouts++;
        end
    endtask

    task automatic load_table();
        // Set 0x35: fill, hits, store miss, then two dirty evictions
        stim[0]  = {1'b0, 32'h00010354, 4'h0, 32'h00000000};
        stim[1]  = {1'b0, 32'h00010354, 4'h0, 32'h00000000};
        stim[2]  = {1'b1, 32'h00010358, 4'h6, 32'hDEADBEEF};
        stim[3]  = {1'b0, 32'h00010358, 4'h0, 32'h00000000};
        stim[4]  = {1'b1, 32'h0002235C, 4'h9, 32'hCAFEF00D};
        stim[5]  = {1'b0, 32'h0002235C, 4'h0, 32'h00000000};
        stim[6]  = {1'b0, 32'h00033350, 4'h0, 32'h00000000};
        stim[7]  = {1'b0, 32'h00010358, 4'h0, 32'h00000000};
        stim[8]  = {1'b0, 32'h0002235C, 4'h0, 32'h00000000};
        // Set 0x7A: full-word and single-byte store misses
        stim[9]  = {1'b1, 32'h000447A0, 4'hF, 32'h11223344};
        stim[10] = {1'b0, 32'h000447A0, 4'h0, 32'h00000000};
        stim[11] = {1'b1, 32'h000557A4, 4'h1, 32'hA5A5A5A5};
        stim[12] = {1'b0, 32'h000667A8, 4'h0, 32'h00000000};
    endtask

    // Memory side with random ready delays and gaps between beats
    always @(posedge clk_g) begin
        if (!resetn) begin
            rd_rdy    <= 1'b0;
            wr_rdy    <= 1'b0;
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            ret_data  <= '0;
            ret_act   <= 1'b0;
            ret_beat  <= '0;
            ret_base  <= '0;
            rd_wait   <= 2;
            wr_wait   <= 2;
        end else begin
            if (wr_req && wr_rdy) begin
                wr_rdy  <= 1'b0;
                wr_wait <= 2 + ($random(seed) & 3);
            end else if (wr_req) begin
                if (wr_wait == 0) begin
                    wr_rdy <= 1'b1;
                end else begin
                    wr_wait <= wr_wait - 1;
                end
            end
            if (rd_req && rd_rdy) begin
                rd_rdy   <= 1'b0;
                rd_wait  <= $random(seed) & 3;
                ret_act  <= 1'b1;
                ret_beat <= '0;
                ret_base <= rd_addr;
            end else if (rd_req) begin
                if (rd_wait == 0) begin
                    rd_rdy <= 1'b1;
                end else begin
                    rd_wait <= rd_wait - 1;
                end
            end
            ret_valid <= 1'b0;
            ret_last  <= 1'b0;
            if (ret_act && ($random(seed) & 3) != 0) begin
                ret_valid <= 1'b1;
                ret_data  <= shadow_read({ret_base[31:4], ret_beat, 2'b00});
                ret_last  <= (ret_beat == 2'd3);
                ret_beat  <= ret_beat + 2'd1;
                if (ret_beat == 2'd3) begin
                    ret_act <= 1'b0;
                end
            end
        end
    end

    initial begin
        clk_g       = 1'b0;
        resetn      = 1'b0;
        valid       = 1'b0;
        op          = 1'b0;
        index       = '0;
        tag         = '0;
        offset      = '0;
        wstrb       = '0;
        wdata       = '0;
        rd_rdy      = 1'b0;
        wr_rdy      = 1'b0;
        ret_valid   = 1'b0;
        ret_last    = 1'b0;
        ret_data    = '0;
        exp_load    = 1'b0;
        exp_hit     = 1'b0;
        exp_wb      = 1'b0;
        exp_rdata   = '0;
        exp_rd_addr = '0;
        exp_wb_addr = '0;
        exp_wb_data = '0;
        seed        = 50;
        timeouts    = 0;
        sh_cnt      = 0;
        m_rr        = 1'b0;
        for (int e = 0; e < 2 * NUM_SETS; e++) begin
            m_valid[e] = 1'b0;
            m_dirty[e] = 1'b0;
        end
        load_table();
        repeat (8) @(posedge clk_g);
        resetn <= 1'b1;
        // A few idle cycles so the checker sees the quiet outputs
        repeat (3) @(posedge clk_g);
        for (int n = 0; n < NUM_STIM && timeouts == 0; n++) begin
            apply_entry(n);
        end
        repeat (4) @(posedge clk_g);
        $display("Summary: %0d errors, %0d timeouts", err_count, timeouts);
        if (err_count == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cache_proj.f
rtl/cache_pkg.sv
rtl/cache_way_store.sv
rtl/cache_ctrl.sv
rtl/cache_write_path.sv
rtl/cache_top.sv
testbench/cache_checker.sv
testbench/tb_cache.sv

//--- Bender.yml
package:
  name: cache_proj

sources:
  - files:
      - rtl/cache_pkg.sv
      - rtl/cache_way_store.sv
      - rtl/cache_ctrl.sv
      - rtl/cache_write_path.sv
      - rtl/cache_top.sv
  - target: test
    files:
      - testbench/cache_checker.sv
      - testbench/tb_cache.sv
